//--- design/core_pkg.sv
package core_pkg;

    localparam int XLEN   = 32;
    localparam int REG_AW = 5;

    localparam logic [XLEN-1:0] DEFAULT_RESET_PC = 32'h0000_0000;

    // one decoded operation per supported instruction
    typedef enum logic [3:0] {
        OP_ADD,
        OP_SUB,
        OP_AND,
        OP_OR,
        OP_XOR,
        OP_ADDI,
        OP_LU12I,
        OP_BEQ,
        OP_BNE,
        OP_NOP
    } op_e;

    // 3R form opcode in inst[31:15]
    localparam logic [16:0] OPC_ADD_W = 17'h00020;
    localparam logic [16:0] OPC_SUB_W = 17'h00022;
    localparam logic [16:0] OPC_AND   = 17'h00029;
    localparam logic [16:0] OPC_OR    = 17'h0002a;
    localparam logic [16:0] OPC_XOR   = 17'h0002b;

    // 2RI12 form opcode in inst[31:22]
    localparam logic [9:0] OPC_ADDI_W = 10'h00a;

    // 1RI20 form opcode in inst[31:25]
    localparam logic [6:0] OPC_LU12I_W = 7'h0a;

    // 2RI16 branch opcodes in inst[31:26]
    localparam logic [5:0] OPC_BEQ = 6'h16;
    localparam logic [5:0] OPC_BNE = 6'h17;

endpackage

//--- design/fetch_unit.sv
`timescale 1ns/1ps

module fetch_unit import core_pkg::*; #(
    parameter logic [XLEN-1:0] RESET_PC = DEFAULT_RESET_PC
) (
    input  logic            clk,
    input  logic            i_arst_n,
    input  logic            i_redirect,
    input  logic [XLEN-1:0] i_redirect_pc,
    input  logic            i_wb_ack,
    input  logic [XLEN-1:0] i_wb_dat,
    output logic            o_wb_cyc,
    output logic            o_wb_stb,
    output logic [XLEN-1:0] o_wb_adr,
    output logic            o_inst_valid,
    output logic [XLEN-1:0] o_inst,
    output logic [XLEN-1:0] o_inst_pc
);

    typedef enum logic {
        S_IDLE,
        S_BUSY
    } req_state_e;

    req_state_e      state;
    logic [XLEN-1:0] pc;

    // request FSM and pc
    always_ff @(posedge clk or negedge i_arst_n) begin
        if (!i_arst_n) begin
            state        <= S_IDLE;
            pc           <= RESET_PC;
            o_inst_valid <= 1'b0;
        end else begin
            o_inst_valid <= 1'b0;
            case (state)
                S_IDLE: begin
                    state <= S_BUSY; // first request after reset or next one after commit
                    if (o_inst_valid) begin
                        pc <= i_redirect ? i_redirect_pc : pc + XLEN'(4);
                    end
                end
                S_BUSY: begin
                    if (i_wb_ack) begin
                        state        <= S_IDLE;
                        o_inst_valid <= 1'b1;
                    end
                end
                default: state <= S_IDLE;
            endcase
        end
    end

    // returned word and its address
    always_ff @(posedge clk) begin
        if (state == S_BUSY && i_wb_ack) begin
            o_inst    <= i_wb_dat;
            o_inst_pc <= pc;
        end
    end

    assign o_wb_cyc = (state == S_BUSY);
    assign o_wb_stb = (state == S_BUSY);
    assign o_wb_adr = pc;

    // wishbone classic holds the request until ack
    a_adr_stable: assert property (@(posedge clk) disable iff (!i_arst_n)
        o_wb_stb && !i_wb_ack |=> o_wb_stb && $stable(o_wb_adr));

    a_adr_aligned: assert property (@(posedge clk) disable iff (!i_arst_n)
        o_wb_stb |-> o_wb_adr[1:0] == 2'b00);

endmodule

//--- design/inst_decoder.sv
`timescale 1ns/1ps

module inst_decoder import core_pkg::*; (
    input  logic [XLEN-1:0]   i_inst,
    output op_e               o_op,
    output logic [REG_AW-1:0] o_rd,
    output logic [REG_AW-1:0] o_rj,
    output logic [REG_AW-1:0] o_rk_or_rd,
    output logic [XLEN-1:0]   o_imm
);

    logic [REG_AW-1:0] rk;
    logic              is_branch;

    assign o_rd = i_inst[4:0];
    assign o_rj = i_inst[9:5];
    assign rk   = i_inst[14:10];

    // widest opcode field is matched first
    always_comb begin
        o_op = OP_NOP;
        if (i_inst[31:15] == OPC_ADD_W) begin
            o_op = OP_ADD;
        end else if (i_inst[31:15] == OPC_SUB_W) begin
            o_op = OP_SUB;
        end else if (i_inst[31:15] == OPC_AND) begin
            o_op = OP_AND;
        end else if (i_inst[31:15] == OPC_OR) begin
            o_op = OP_OR;
        end else if (i_inst[31:15] == OPC_XOR) begin
            o_op = OP_XOR;
        end else if (i_inst[31:22] == OPC_ADDI_W) begin
            o_op = OP_ADDI;
        end else if (i_inst[31:25] == OPC_LU12I_W) begin
            o_op = OP_LU12I;
        end else if (i_inst[31:26] == OPC_BEQ) begin
            o_op = OP_BEQ;
        end else if (i_inst[31:26] == OPC_BNE) begin
            o_op = OP_BNE;
        end
    end

    assign is_branch = (o_op == OP_BEQ) || (o_op == OP_BNE);

    // branches compare rj against rd
    assign o_rk_or_rd = is_branch ? o_rd : rk;

    always_comb begin
        case (o_op)
            OP_ADDI:  o_imm = {{20{i_inst[21]}}, i_inst[21:10]};    // si12
            OP_LU12I: o_imm = {i_inst[24:5], 12'b0};                // si20 << 12
            OP_BEQ,
            OP_BNE:   o_imm = {{14{i_inst[25]}}, i_inst[25:10], 2'b00}; // offs16 << 2
            default:  o_imm = '0;
        endcase
    end

endmodule

//--- design/reg_file.sv
`timescale 1ns/1ps

module reg_file import core_pkg::*; (
    input  logic              clk,
    input  logic              i_arst_n,
    input  logic [REG_AW-1:0] i_raddr_a,
    input  logic [REG_AW-1:0] i_raddr_b,
    input  logic              i_we,
    input  logic [REG_AW-1:0] i_waddr,
    input  logic [XLEN-1:0]   i_wdata,
    output logic [XLEN-1:0]   o_rdata_a,
    output logic [XLEN-1:0]   o_rdata_b
);

    logic [XLEN-1:0] regs [0:(1 << REG_AW)-1];

    always_ff @(posedge clk or negedge i_arst_n) begin
        if (!i_arst_n) begin
            for (int i = 0; i < (1 << REG_AW); i++) begin
                regs[i] <= '0;
            end
        end else if (i_we && i_waddr != '0) begin // r0 is never written
            regs[i_waddr] <= i_wdata;
        end
    end

    // async read with r0 reading as zero
    assign o_rdata_a = (i_raddr_a == '0) ? '0 : regs[i_raddr_a];
    assign o_rdata_b = (i_raddr_b == '0) ? '0 : regs[i_raddr_b];

endmodule

//--- design/exec_unit.sv
`timescale 1ns/1ps

module exec_unit import core_pkg::*; (
    input  logic              clk,
    input  logic              i_arst_n,
    input  logic              i_valid,
    input  logic [XLEN-1:0]   i_pc,
    input  op_e               i_op,
    input  logic [REG_AW-1:0] i_rd,
    input  logic [XLEN-1:0]   i_imm,
    input  logic [XLEN-1:0]   i_src_a,
    input  logic [XLEN-1:0]   i_src_b,
    output logic              o_rf_we,
    output logic [REG_AW-1:0] o_rf_waddr,
    output logic [XLEN-1:0]   o_rf_wdata,
    output logic              o_redirect,
    output logic [XLEN-1:0]   o_redirect_pc,
    output logic              o_debug_wb_valid,
    output logic [XLEN-1:0]   o_debug_wb_pc,
    output logic [3:0]        o_debug_wb_rf_we,
    output logic [REG_AW-1:0] o_debug_wb_rf_wnum,
    output logic [XLEN-1:0]   o_debug_wb_rf_wdata
);

    logic [XLEN-1:0] alu_res;
    logic            writes_rd;
    logic            taken;

    always_comb begin
        writes_rd = 1'b1;
        case (i_op)
            OP_ADD:   alu_res = i_src_a + i_src_b;
            OP_SUB:   alu_res = i_src_a - i_src_b;
            OP_AND:   alu_res = i_src_a & i_src_b;
            OP_OR:    alu_res = i_src_a | i_src_b;
            OP_XOR:   alu_res = i_src_a ^ i_src_b;
            OP_ADDI:  alu_res = i_src_a + i_imm;
            OP_LU12I: alu_res = i_imm;
            default: begin
                alu_res   = '0;
                writes_rd = 1'b0; // branches and nop
            end
        endcase
    end

    // src_b carries rd for branches
    assign taken = (i_op == OP_BEQ && i_src_a == i_src_b)
                || (i_op == OP_BNE && i_src_a != i_src_b);

    assign o_redirect    = i_valid && taken;
    assign o_redirect_pc = i_pc + i_imm;

    assign o_rf_we    = i_valid && writes_rd;
    assign o_rf_waddr = i_rd;
    assign o_rf_wdata = alu_res;

    always_ff @(posedge clk or negedge i_arst_n) begin
        if (!i_arst_n) begin
            o_debug_wb_valid <= 1'b0;
        end else begin
            o_debug_wb_valid <= i_valid;
        end
    end

    // commit record captured with the register write
    always_ff @(posedge clk) begin
        if (i_valid) begin
            o_debug_wb_pc       <= i_pc;
            o_debug_wb_rf_we    <= {4{o_rf_we}};
            o_debug_wb_rf_wnum  <= i_rd;
            o_debug_wb_rf_wdata <= alu_res;
        end
    end

    a_redirect_valid: assert property (@(posedge clk) disable iff (!i_arst_n)
        o_redirect |-> i_valid);

    // fetch delivers single-cycle pulses
    a_one_in_flight: assert property (@(posedge clk) disable iff (!i_arst_n)
        i_valid |=> !i_valid);

endmodule

//--- design/mini_core_top.sv
`timescale 1ns/1ps

module mini_core_top import core_pkg::*; #(
    parameter logic [XLEN-1:0] RESET_PC = DEFAULT_RESET_PC
) (
    input  logic              clk,
    input  logic              i_arst_n,
    output logic              o_wb_cyc,
    output logic              o_wb_stb,
    output logic [XLEN-1:0]   o_wb_adr,
    input  logic              i_wb_ack,
    input  logic [XLEN-1:0]   i_wb_dat,
    output logic              o_debug_wb_valid,
    output logic [XLEN-1:0]   o_debug_wb_pc,
    output logic [3:0]        o_debug_wb_rf_we,
    output logic [REG_AW-1:0] o_debug_wb_rf_wnum,
    output logic [XLEN-1:0]   o_debug_wb_rf_wdata
);

    logic              inst_valid;
    logic [XLEN-1:0]   inst;
    logic [XLEN-1:0]   inst_pc;
    op_e               op;
    logic [REG_AW-1:0] rd;
    logic [REG_AW-1:0] rj;
    logic [REG_AW-1:0] rk_or_rd;
    logic [XLEN-1:0]   imm;
    logic [XLEN-1:0]   src_a;
    logic [XLEN-1:0]   src_b;
    logic              rf_we;
    logic [REG_AW-1:0] rf_waddr;
    logic [XLEN-1:0]   rf_wdata;
    logic              redirect;
    logic [XLEN-1:0]   redirect_pc;

    fetch_unit #(
        .RESET_PC(RESET_PC)
    ) u_fetch (
        .clk(clk), .i_arst_n(i_arst_n),
        .i_redirect(redirect), .i_redirect_pc(redirect_pc),
        .i_wb_ack(i_wb_ack), .i_wb_dat(i_wb_dat),
        .o_wb_cyc(o_wb_cyc), .o_wb_stb(o_wb_stb), .o_wb_adr(o_wb_adr),
        .o_inst_valid(inst_valid), .o_inst(inst), .o_inst_pc(inst_pc)
    );

    inst_decoder u_dec (
        .i_inst(inst), .o_op(op), .o_rd(rd), .o_rj(rj),
        .o_rk_or_rd(rk_or_rd), .o_imm(imm)
    );

    reg_file u_rf (
        .clk(clk), .i_arst_n(i_arst_n),
        .i_raddr_a(rj), .i_raddr_b(rk_or_rd),
        .i_we(rf_we), .i_waddr(rf_waddr), .i_wdata(rf_wdata),
        .o_rdata_a(src_a), .o_rdata_b(src_b)
    );

    exec_unit u_exec (
        .clk(clk), .i_arst_n(i_arst_n),
        .i_valid(inst_valid), .i_pc(inst_pc), .i_op(op), .i_rd(rd), .i_imm(imm),
        .i_src_a(src_a), .i_src_b(src_b),
        .o_rf_we(rf_we), .o_rf_waddr(rf_waddr), .o_rf_wdata(rf_wdata),
        .o_redirect(redirect), .o_redirect_pc(redirect_pc),
        .o_debug_wb_valid(o_debug_wb_valid), .o_debug_wb_pc(o_debug_wb_pc),
        .o_debug_wb_rf_we(o_debug_wb_rf_we), .o_debug_wb_rf_wnum(o_debug_wb_rf_wnum),
        .o_debug_wb_rf_wdata(o_debug_wb_rf_wdata)
    );

endmodule

//--- test/tb_mini_core.sv
`timescale 1ns/1ps

module tb_mini_core;

    localparam logic [31:0] RESET_PC = 32'h0000_0100;
    localparam logic [31:0] SEED     = 32'hfb41_4cf6;
    localparam int          TIMEOUT  = 5000;

    // LoongArch32 opcode field values
    localparam logic [16:0] E_ADD   = 17'h00020;
    localparam logic [16:0] E_SUB   = 17'h00022;
    localparam logic [16:0] E_AND   = 17'h00029;
    localparam logic [16:0] E_OR    = 17'h0002a;
    localparam logic [16:0] E_XOR   = 17'h0002b;
    localparam logic [9:0]  E_ADDI  = 10'h00a;
    localparam logic [6:0]  E_LU12I = 7'h0a;
    localparam logic [5:0]  E_BEQ   = 6'h16;
    localparam logic [5:0]  E_BNE   = 6'h17;

    logic        clk = 1'b0;
    logic        i_arst_n;
    logic        o_wb_cyc;
    logic        o_wb_stb;
    logic [31:0] o_wb_adr;
    logic        i_wb_ack;
    logic [31:0] i_wb_dat;
    logic        o_debug_wb_valid;
    logic [31:0] o_debug_wb_pc;
    logic [3:0]  o_debug_wb_rf_we;
    logic [4:0]  o_debug_wb_rf_wnum;
    logic [31:0] o_debug_wb_rf_wdata;

    logic [31:0] mem [0:1023];
    logic [31:0] req_adr [0:1023];   // address of each bus request in issue order
    logic [1:0]  delay_tab [0:1023]; // ack wait states per request
    logic [31:0] model_rf [0:31];
    logic [31:0] model_pc;
    logic [31:0] lfsr;
    logic [9:0]  wr_idx;
    logic [31:0] halt_pc;
    logic        done = 1'b0;
    int          req_cnt = 0;
    int          commits = 0;
    int          halt_hits = 0;
    int          chk_reset = 0;
    int          err_reset = 0;
    int          chk_bus = 0;
    int          err_bus = 0;
    int          chk_commit = 0;
    int          err_commit = 0;

    mini_core_top #(
        .RESET_PC(RESET_PC)
    ) dut (
        .clk(clk), .i_arst_n(i_arst_n),
        .o_wb_cyc(o_wb_cyc), .o_wb_stb(o_wb_stb), .o_wb_adr(o_wb_adr),
        .i_wb_ack(i_wb_ack), .i_wb_dat(i_wb_dat),
        .o_debug_wb_valid(o_debug_wb_valid), .o_debug_wb_pc(o_debug_wb_pc),
        .o_debug_wb_rf_we(o_debug_wb_rf_we), .o_debug_wb_rf_wnum(o_debug_wb_rf_wnum),
        .o_debug_wb_rf_wdata(o_debug_wb_rf_wdata)
    );

    always #4 clk = ~clk;

    // galois lfsr stepped once per bit taken
    function automatic logic [31:0] rand_bits(input int n);
        logic [31:0] r;
        r = '0;
        for (int i = 0; i < n; i++) begin
            r    = {r[30:0], lfsr[0]};
            lfsr = (lfsr >> 1) ^ (lfsr[0] ? 32'h8020_0003 : 32'h0);
        end
        return r;
    endfunction

    function automatic logic [31:0] enc_3r(input logic [16:0] opc,
                                           input logic [4:0] rd, rj, rk);
        return {opc, rk, rj, rd};
    endfunction

    function automatic logic [31:0] enc_2ri12(input logic [4:0] rd, rj, input logic [11:0] si);
        return {E_ADDI, si, rj, rd};
    endfunction

    function automatic logic [31:0] enc_1ri20(input logic [4:0] rd, input logic [19:0] si);
        return {E_LU12I, si, rd};
    endfunction

    function automatic logic [31:0] enc_2ri16(input logic [5:0] opc, input logic [4:0] rj, rd,
                                              input logic [15:0] offs);
        return {opc, offs, rj, rd};
    endfunction

    // ISA reference model returning the next pc and the expected commit record
    function automatic logic [31:0] ref_exec(input logic [31:0] w, input logic [31:0] pc,
                                             output logic wr, output logic [4:0] wn,
                                             output logic [31:0] wd);
        logic [31:0] a;
        logic [31:0] b;
        logic [31:0] d;
        a        = model_rf[w[9:5]];
        b        = model_rf[w[14:10]];
        d        = model_rf[w[4:0]];
        wr       = 1'b1;
        wn       = w[4:0];
        wd       = '0;
        ref_exec = pc + 32'd4;
        if (w[31:15] == E_ADD) wd = a + b;
        else if (w[31:15] == E_SUB) wd = a - b;
        else if (w[31:15] == E_AND) wd = a & b;
        else if (w[31:15] == E_OR) wd = a | b;
        else if (w[31:15] == E_XOR) wd = a ^ b;
        else if (w[31:22] == E_ADDI) wd = a + {{20{w[21]}}, w[21:10]};
        else if (w[31:25] == E_LU12I) wd = {w[24:5], 12'h000};
        else begin
            wr = 1'b0; // branches and unknown words write nothing
            if ((w[31:26] == E_BEQ && a == d) || (w[31:26] == E_BNE && a != d))
                ref_exec = pc + {{14{w[25]}}, w[25:10], 2'b00};
        end
    endfunction

    task automatic emit(input logic [31:0] w);
        mem[wr_idx] = w;
        wr_idx      = wr_idx + 10'd1;
    endtask

    task automatic build_program();
        logic [2:0] sel;
        logic [4:0] rd;
        logic [4:0] rj;
        logic [4:0] rk;
        for (int i = 0; i < 1024; i++) begin
            mem[i] = 32'hfc00_0000 | (32'(i) << 2); // decodes as nop
        end
        wr_idx = RESET_PC[11:2];
        for (int r = 1; r < 9; r++) begin
            emit(enc_1ri20(5'(r), 20'(rand_bits(20))));
            emit(enc_2ri12(5'(r), 5'(r), 12'(rand_bits(12))));
        end
        for (int n = 0; n < 48; n++) begin
            sel = 3'(rand_bits(3));
            rd  = 5'(rand_bits(4));
            rj  = 5'(rand_bits(4));
            rk  = 5'(rand_bits(4));
            case (sel)
                3'd0: emit(enc_3r(E_ADD, rd, rj, rk));
                3'd1: emit(enc_3r(E_SUB, rd, rj, rk));
                3'd2: emit(enc_3r(E_AND, rd, rj, rk));
                3'd3: emit(enc_3r(E_OR, rd, rj, rk));
                3'd4: emit(enc_3r(E_XOR, rd, rj, rk));
                3'd5: emit(enc_2ri12(rd, rj, 12'(rand_bits(12))));
                default: emit(enc_1ri20(rd, 20'(rand_bits(20))));
            endcase
        end
        emit(enc_2ri12(5'd0, 5'd1, 12'd5));           // write to r0
        emit(enc_3r(E_ADD, 5'd2, 5'd0, 5'd0));        // r0 must read zero
        emit(32'hffff_ffff);
        emit(enc_2ri12(5'd20, 5'd0, 12'd5));
        emit(enc_2ri12(5'd22, 5'd0, 12'd0));
        emit(enc_2ri12(5'd20, 5'd20, 12'hfff));       // countdown loop body
        emit(enc_3r(E_ADD, 5'd22, 5'd22, 5'd20));
        emit(enc_2ri16(E_BNE, 5'd20, 5'd0, 16'hfffe)); // back two words
        emit(enc_2ri16(E_BEQ, 5'd1, 5'd2, 16'd2));
        emit(enc_2ri16(E_BEQ, 5'd20, 5'd0, 16'd2));   // taken and skips one word
        emit(enc_2ri12(5'd23, 5'd0, 12'd1));
        emit(enc_2ri16(E_BNE, 5'd0, 5'd0, 16'd2));
        halt_pc = {20'h0, wr_idx, 2'b00};
        emit(enc_2ri16(E_BEQ, 5'd0, 5'd0, 16'd0));    // branch to itself
    endtask

    task automatic check_idle(input string when_s);
        chk_reset++;
        if (o_wb_cyc || o_wb_stb || o_debug_wb_valid) begin
            err_reset++;
            $display("FAIL @%0t: bus or commit active %s", $time, when_s);
        end
    endtask

    // wishbone memory with random wait states
    initial begin
        logic        pending;
        logic [31:0] cur_adr;
        logic [1:0]  wait_left;
        i_wb_ack <= 1'b0;
        i_wb_dat <= '0;
        pending = 1'b0;
        forever begin
            @(posedge clk);
            if (!i_arst_n || i_wb_ack) begin
                i_wb_ack <= 1'b0;
                pending = 1'b0;
            end else if (o_wb_stb) begin
                chk_bus++;
                if (!pending) begin
                    pending   = 1'b1;
                    cur_adr   = o_wb_adr;
                    wait_left = delay_tab[req_cnt[9:0]];
                    if (req_cnt == 0 && o_wb_adr != RESET_PC) begin
                        err_bus++;
                        $display("FAIL @%0t: first request at %h", $time, o_wb_adr);
                    end
                    req_adr[req_cnt[9:0]] = o_wb_adr;
                    req_cnt++;
                end else if (!o_wb_cyc || o_wb_adr != cur_adr) begin
                    err_bus++;
                    $display("FAIL @%0t: request moved to %h before ack", $time, o_wb_adr);
                end
                if (wait_left == 2'd0) begin
                    i_wb_ack <= 1'b1;
                    i_wb_dat <= mem[o_wb_adr[11:2]];
                end else begin
                    wait_left = wait_left - 2'd1;
                end
            end
        end
    end

    // commit checker
    always @(posedge clk) begin
        logic [31:0] nxt;
        logic        wr;
        logic [4:0]  wn;
        logic [31:0] wd;
        if (!i_arst_n) begin
            for (int r = 0; r < 32; r++) begin
                model_rf[r] = '0;
            end
            model_pc = RESET_PC;
        end else if (o_debug_wb_valid) begin
            chk_commit++;
            if (commits >= req_cnt) begin
                err_commit++;
                $display("commit %0d retired with no bus request behind it", commits);
            end else if (req_adr[commits[9:0]] != model_pc) begin
                err_commit++;
                $display("FAIL @%0t: request %h, model pc %h", $time,
                         req_adr[commits[9:0]], model_pc);
            end
            if (o_debug_wb_pc != model_pc) begin
                err_commit++;
                $display("FAIL @%0t: commit pc %h, expected %h", $time, o_debug_wb_pc, model_pc);
            end
            nxt = ref_exec(mem[model_pc[11:2]], model_pc, wr, wn, wd);
            if (o_debug_wb_rf_we != {4{wr}} || (wr && (o_debug_wb_rf_wnum != wn
                    || o_debug_wb_rf_wdata != wd))) begin
                err_commit++;
                $display("FAIL @%0t: pc %h we=%h r%0d=%h, expected we=%h r%0d=%h", $time,
                         model_pc, o_debug_wb_rf_we, o_debug_wb_rf_wnum, o_debug_wb_rf_wdata,
                         {4{wr}}, wn, wd);
            end
            if (wr && wn != 5'd0) model_rf[wn] = wd;
            if (model_pc == halt_pc) halt_hits++;
            done     = (halt_hits >= 2);
            model_pc = nxt;
            commits++;
        end
    end

    initial begin
        int cycles;
        i_arst_n <= 1'b0;
        lfsr = SEED;
        build_program();
        for (int i = 0; i < 1024; i++) begin
            delay_tab[i] = 2'(rand_bits(2));
        end
        for (cycles = 0; cycles < 4; cycles++) begin
            @(posedge clk);
            if (cycles > 0) check_idle("during reset"); // first edge applies the reset
        end
        i_arst_n <= 1'b1;
        @(posedge clk);
        check_idle("right after reset");
        for (cycles = 0; cycles < TIMEOUT && !done; cycles++) begin
            @(posedge clk);
        end
        if (!done) begin
            err_commit++;
            $display("timed out before the program reached its final branch");
        end
        $display("%0d checks, %0d errors (reset %0d, bus %0d, commit %0d), %0d commits",
                 chk_reset + chk_bus + chk_commit, err_reset + err_bus + err_commit,
                 err_reset, err_bus, err_commit, commits);
        if (err_reset + err_bus + err_commit == 0) begin
            $display("TEST PASS");
        end else begin
            $display("TEST FAIL");
        end
        $finish;
    end

endmodule

//--- mini_core.f
design/core_pkg.sv
design/fetch_unit.sv
design/inst_decoder.sv
design/reg_file.sv
design/exec_unit.sv
design/mini_core_top.sv
test/tb_mini_core.sv

//--- run_sim.sh
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -j 0 \
    --top-module tb_mini_core -f mini_core.f -o sim_mini_core

out=$(./obj_dir/sim_mini_core)
echo "$out"
echo "$out" | grep -qx "TEST PASS"
